//--- hw/pipeline_pkg.sv
// Pipeline control package.
// Shared types for decode, hazard control, PC and stage tracking.
`default_nettype none

package pipeline_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regnum_t;

  // Fetch starts here after reset.
  localparam word_t RESET_PC = 32'h0000_0000;

  // Operation classes seen by the hazard logic.
  typedef enum logic [3:0] {
    OTHERR = 4'h0,
    OSL    = 4'h1,
    OTHERI = 4'h2,
    OLW    = 4'h3,
    OSW    = 4'h4,
    OBEQ   = 4'h5,
    OBNE   = 4'h6,
    OJ     = 4'h7,
    OJAL   = 4'h8,
    OJR    = 4'h9,
    ONOP   = 4'hA,
    OHALT  = 4'hB
  } opfunc_t;

  typedef enum logic [1:0] {
    PCNPC = 2'd0,
    PCBPC = 2'd1,
    PCPTA = 2'd2,
    PCJPC = 2'd3
  } pcsel_t;

  // MIPS primary opcodes.
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDI  = 6'h08,
    OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0A,
    OP_SLTIU = 6'h0B,
    OP_ANDI  = 6'h0C,
    OP_ORI   = 6'h0D,
    OP_XORI  = 6'h0E,
    OP_LUI   = 6'h0F,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B,
    OP_HALT  = 6'h3F
  } opcode_t;

  // R-type funct codes that need their own class.
  typedef enum logic [5:0] {
    FN_SLL = 6'h00,
    FN_SRL = 6'h02,
    FN_SRA = 6'h03,
    FN_JR  = 6'h08
  } funct_t;

  // One instruction as it moves down the pipe.
  typedef struct packed {
    logic    valid;
    opfunc_t opfunc;
    regnum_t rs;
    regnum_t rt;
    word_t   pc;
    word_t   target;
  } stage_tag_t;

  typedef struct packed {
    pcsel_t pcsel;
    logic   pc_en;
    logic   ifid_en;
    logic   idex_en;
    logic   exmm_en;
    logic   mmwb_en;
    logic   ifid_flush;
    logic   idex_flush;
    logic   exmm_flush;
  } hazard_ctrl_t;

endpackage

`default_nettype wire

//--- hw/instr_decoder.sv
// Instruction decoder.
// Maps a fetched MIPS word to an operation class, register fields and target.
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  pipeline_pkg::word_t      instr,
  input  pipeline_pkg::word_t      pc,
  input  logic                     ihit,
  output pipeline_pkg::stage_tag_t tag
);
  import pipeline_pkg::*;

  opcode_t     opcode;
  funct_t      funct;
  logic [15:0] imm;
  logic [25:0] jidx;
  word_t       pc_plus4;
  word_t       br_target;
  word_t       j_target;
  opfunc_t     op;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);
  assign imm    = instr[15:0];
  assign jidx   = instr[25:0];

  assign pc_plus4  = pc + 32'd4;
  // Word offset, sign extended.
  assign br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
  assign j_target  = {pc_plus4[31:28], jidx, 2'b00};

  always_comb begin
    op = ONOP;
    case (opcode)
      OP_RTYPE: begin
        case (funct)
          FN_SLL, FN_SRL, FN_SRA: op = OSL;
          FN_JR:                  op = OJR;
          default:                op = OTHERR;
        endcase
        // All-zero word is the canonical nop.
        if (instr == '0) begin
          op = ONOP;
        end
      end
      OP_J:   op = OJ;
      OP_JAL: op = OJAL;
      OP_BEQ: op = OBEQ;
      OP_BNE: op = OBNE;
      OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
      OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        op = OTHERI;
      end
      OP_LW:   op = OLW;
      OP_SW:   op = OSW;
      OP_HALT: op = OHALT;
      default: op = ONOP;
    endcase
  end

  always_comb begin
    tag.valid  = ihit;
    tag.opfunc = op;
    tag.rs     = instr[25:21];
    tag.rt     = instr[20:16];
    tag.pc     = pc;
    if (op == OJ || op == OJAL) begin
      tag.target = j_target;
    end else begin
      tag.target = br_target;
    end
  end

endmodule

`default_nettype wire

//--- hw/hazard_control_unit.sv
// Hazard control unit.
// Drives PC select, stage enables and flushes from the stage tags and cache hits.
`timescale 1ns/1ps
`default_nettype none

module hazard_control_unit (
  input  pipeline_pkg::stage_tag_t   id_tag,
  input  pipeline_pkg::stage_tag_t   ex_tag,
  input  pipeline_pkg::stage_tag_t   mm_tag,
  input  logic                       ihit,
  input  logic                       dhit,
  input  logic                       mm_equal,
  output pipeline_pkg::hazard_ctrl_t ctrl
);
  import pipeline_pkg::*;

  opfunc_t id_op;
  opfunc_t ex_op;
  opfunc_t mm_op;
  logic    reads_rs_rt;
  logic    reads_rs;
  logic    match_rs;
  logic    match_rt;
  logic    hzd_mem;
  logic    hzd_lduse;
  logic    hzd_br;
  logic    hzd_jr;
  logic    hzd_j;

  // Empty slots behave as nops.
  assign id_op = id_tag.valid ? id_tag.opfunc : ONOP;
  assign ex_op = ex_tag.valid ? ex_tag.opfunc : ONOP;
  assign mm_op = mm_tag.valid ? mm_tag.opfunc : ONOP;

  // Shifts read rt, so they sit with the two-source group.
  assign reads_rs_rt = (id_op == OTHERR || id_op == OSL || id_op == OBEQ ||
                        id_op == OBNE || id_op == OSW);
  assign reads_rs    = (id_op == OJR || id_op == OLW || id_op == OTHERI);

  assign match_rs = (id_tag.rs == ex_tag.rt);
  assign match_rt = (id_tag.rt == ex_tag.rt);

  assign hzd_mem   = (mm_op == OLW || mm_op == OSW);
  assign hzd_lduse = (ex_op == OLW) &&
                     (((reads_rs || reads_rs_rt) && match_rs) ||
                      (reads_rs_rt && match_rt));
  assign hzd_br    = (mm_op == OBEQ && mm_equal) || (mm_op == OBNE && !mm_equal);
  assign hzd_jr    = (ex_op == OJR) && !hzd_br;
  assign hzd_j     = (ex_op == OJ || ex_op == OJAL) && !hzd_br;

  // Rules in priority order, later ones win.
  always_comb begin
    ctrl.pcsel      = PCNPC;
    ctrl.pc_en      = ihit;
    ctrl.ifid_en    = ihit;
    ctrl.idex_en    = ihit;
    ctrl.exmm_en    = ihit;
    ctrl.mmwb_en    = ihit;
    ctrl.ifid_flush = 1'b0;
    ctrl.idex_flush = 1'b0;
    ctrl.exmm_flush = 1'b0;
    if (hzd_mem) begin
      ctrl.pc_en      = ihit && dhit;
      ctrl.ifid_en    = dhit;
      ctrl.idex_en    = dhit;
      ctrl.exmm_en    = dhit;
      ctrl.mmwb_en    = dhit;
      ctrl.ifid_flush = !ihit && dhit;
    end
    if (hzd_lduse) begin
      ctrl.pc_en      = 1'b0;
      ctrl.ifid_en    = 1'b0;
      ctrl.idex_flush = 1'b1;
    end
    if (hzd_br) begin
      ctrl.pcsel      = PCBPC;
      ctrl.pc_en      = ihit;
      ctrl.ifid_en    = ihit;
      ctrl.ifid_flush = 1'b1;
      ctrl.idex_flush = 1'b1;
      ctrl.exmm_flush = 1'b1;
    end
    if (hzd_jr || hzd_j) begin
      ctrl.pcsel      = hzd_jr ? PCPTA : PCJPC;
      ctrl.pc_en      = ihit || dhit;
      ctrl.ifid_flush = 1'b1;
      ctrl.idex_flush = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/pc_unit.sv
// Program counter.
// Loads the next fetch address from the source chosen by the hazard unit.
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
  parameter pipeline_pkg::word_t START_PC = pipeline_pkg::RESET_PC
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  pipeline_pkg::hazard_ctrl_t ctrl,
  input  pipeline_pkg::word_t        mm_target,
  input  pipeline_pkg::word_t        ex_target,
  input  pipeline_pkg::word_t        jr_target,
  output pipeline_pkg::word_t        pc
);
  import pipeline_pkg::*;

  word_t pc_seq;
  word_t pc_next;

  assign pc_seq = pc + 32'd4;

  always_comb begin
    case (ctrl.pcsel)
      PCBPC:   pc_next = mm_target;
      PCPTA:   pc_next = jr_target;
      PCJPC:   pc_next = ex_target;
      default: pc_next = pc_seq;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= START_PC;
    end else if (ctrl.pc_en) begin
      pc <= pc_next;
    end
  end

  // Holds as long as register targets from the data path are aligned.
  assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("misaligned PC %h", pc);

endmodule

`default_nettype wire

//--- hw/pipeline_tracker.sv
// Pipeline tracker.
// Moves instruction tags through IF/ID, ID/EX, EX/MM and MM/WB and flags retirement.
`timescale 1ns/1ps
`default_nettype none

module pipeline_tracker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  pipeline_pkg::stage_tag_t   if_tag,
  input  pipeline_pkg::hazard_ctrl_t ctrl,
  output pipeline_pkg::stage_tag_t   id_tag,
  output pipeline_pkg::stage_tag_t   ex_tag,
  output pipeline_pkg::stage_tag_t   mm_tag,
  output logic                       retire_valid,
  output pipeline_pkg::word_t        retire_pc,
  output pipeline_pkg::opfunc_t      retire_op
);
  import pipeline_pkg::*;

  localparam int NSTAGE = 4;

  // Index 0 is IF/ID, 3 is MM/WB.
  stage_tag_t        stg [NSTAGE];
  stage_tag_t        nxt [NSTAGE];
  logic [NSTAGE-1:0] en;
  logic [NSTAGE-1:0] flush;

  assign en    = {ctrl.mmwb_en, ctrl.exmm_en, ctrl.idex_en, ctrl.ifid_en};
  // MM/WB is never flushed.
  assign flush = {1'b0, ctrl.exmm_flush, ctrl.idex_flush, ctrl.ifid_flush};

  assign nxt[0] = if_tag;
  assign nxt[1] = stg[0];
  assign nxt[2] = stg[1];
  assign nxt[3] = stg[2];

  // Flush wins over enable and drops in an empty slot.
  always_ff @(posedge clk) begin
    for (int i = 0; i < NSTAGE; i++) begin
      if (!rst_n || flush[i]) begin
        stg[i] <= '0;
      end else if (en[i]) begin
        stg[i] <= nxt[i];
      end
    end
  end

  assign id_tag = stg[0];
  assign ex_tag = stg[1];
  assign mm_tag = stg[2];

  // WB tag retires on the edge that moves it out.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= ctrl.mmwb_en && stg[3].valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.mmwb_en) begin
      retire_pc <= stg[3].pc;
      retire_op <= stg[3].opfunc;
    end
  end

  // A bubble made by an EX/MM flush never shows up at the retire port.
  assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.exmm_flush ##1 ctrl.mmwb_en [->2] |=> !retire_valid)
    else $error("flushed slot retired");

endmodule

`default_nettype wire

//--- hw/pipeline_control_top.sv
// Pipeline control top level.
// Ties the decoder, hazard unit, PC unit and stage tracker together.
`timescale 1ns/1ps
`default_nettype none

module pipeline_control_top #(
  parameter pipeline_pkg::word_t START_PC = pipeline_pkg::RESET_PC
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pipeline_pkg::word_t   instr,
  input  logic                  ihit,
  input  logic                  dhit,
  input  logic                  mm_equal,
  input  pipeline_pkg::word_t   jr_target,
  output pipeline_pkg::word_t   imem_addr,
  output logic                  retire_valid,
  output pipeline_pkg::word_t   retire_pc,
  output pipeline_pkg::opfunc_t retire_op
);
  import pipeline_pkg::*;

  stage_tag_t   if_tag;
  stage_tag_t   id_tag;
  stage_tag_t   ex_tag;
  stage_tag_t   mm_tag;
  hazard_ctrl_t ctrl;

  instr_decoder u_decoder (
    .instr (instr),
    .pc    (imem_addr),
    .ihit  (ihit),
    .tag   (if_tag)
  );

  hazard_control_unit u_hazard (
    .id_tag   (id_tag),
    .ex_tag   (ex_tag),
    .mm_tag   (mm_tag),
    .ihit     (ihit),
    .dhit     (dhit),
    .mm_equal (mm_equal),
    .ctrl     (ctrl)
  );

  pc_unit #(
    .START_PC (START_PC)
  ) u_pc (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .mm_target (mm_tag.target),
    .ex_target (ex_tag.target),
    .jr_target (jr_target),
    .pc        (imem_addr)
  );

  pipeline_tracker u_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_tag       (if_tag),
    .ctrl         (ctrl),
    .id_tag       (id_tag),
    .ex_tag       (ex_tag),
    .mm_tag       (mm_tag),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_op    (retire_op)
  );

endmodule

`default_nettype wire

//--- testbench/tb_pipeline_control.sv
// Testbench for the pipeline control top level.
// Replays per-cycle vectors and checks fetch address and retirement.
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_control;
  import pipeline_pkg::*;

  localparam int RESET_TIMEOUT = 20;
  localparam int DRAIN_TIMEOUT = 20;

  logic    clk;
  logic    rst_n;
  word_t   instr;
  logic    ihit;
  logic    dhit;
  logic    mm_equal;
  word_t   jr_target;
  word_t   imem_addr;
  logic    retire_valid;
  word_t   retire_pc;
  opfunc_t retire_op;

  int errors;
  int lines;

  // Instruction word seen at each fetched address.
  word_t fetched [word_t];

  pipeline_control_top #(
    .START_PC (RESET_PC)
  ) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr        (instr),
    .ihit         (ihit),
    .dhit         (dhit),
    .mm_equal     (mm_equal),
    .jr_target    (jr_target),
    .imem_addr    (imem_addr),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_op    (retire_op)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Operation class of a MIPS word, from the primary opcode and funct fields.
  function automatic opfunc_t expected_class(input word_t w);
    logic [5:0] op;
    logic [5:0] fn;
    opfunc_t    cls;
    op  = w[31:26];
    fn  = w[5:0];
    cls = ONOP;
    if (op == 6'h00) begin
      if (fn == 6'h08) begin
        cls = OJR;
      end else if (fn == 6'h00 || fn == 6'h02 || fn == 6'h03) begin
        cls = OSL;
      end else begin
        cls = OTHERR;
      end
    end else if (op == 6'h02) begin
      cls = OJ;
    end else if (op == 6'h03) begin
      cls = OJAL;
    end else if (op == 6'h04) begin
      cls = OBEQ;
    end else if (op == 6'h05) begin
      cls = OBNE;
    end else if (op >= 6'h08 && op <= 6'h0F) begin
      cls = OTHERI;
    end else if (op == 6'h23) begin
      cls = OLW;
    end else if (op == 6'h2B) begin
      cls = OSW;
    end else if (op == 6'h3F) begin
      cls = OHALT;
    end
    // sll $0,$0,0 is the nop.
    if (w == 32'h0) begin
      cls = ONOP;
    end
    return cls;
  endfunction

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_op(input opfunc_t exp, input opfunc_t act);
    if (act !== exp) begin
      $display("** Error at %0t: retire_op expected %s, got %s",
               $time, exp.name(), act.name());
      errors++;
    end
  endtask

  initial begin
    int    fd;
    int    cnt;
    int    wait_cycles;
    string line;
    word_t v_instr;
    word_t v_jr;
    word_t v_addr;
    word_t v_rpc;
    logic  v_ihit;
    logic  v_dhit;
    logic  v_eq;
    logic  v_rv;
    logic  timed_out;

    errors    = 0;
    lines     = 0;
    timed_out = 1'b0;
    rst_n     = 1'b0;
    instr     = '0;
    ihit      = 1'b0;
    dhit      = 1'b0;
    mm_equal  = 1'b0;
    jr_target = '0;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // Fetch sits at the reset vector with no retire pending.
    @(negedge clk);
    wait_cycles = 0;
    while ((imem_addr !== RESET_PC || retire_valid !== 1'b0) &&
           wait_cycles < RESET_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (imem_addr !== RESET_PC || retire_valid !== 1'b0) begin
      $display("Timed out waiting for the reset state of fetch and retire");
      timed_out = 1'b1;
    end

    fd = $fopen("testbench/pipeline_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        if ($fgets(line, fd) == 0) begin
          break;
        end
        if (line.len() == 0 || line.substr(0, 0) == "#") begin
          continue;
        end
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h", v_instr, v_ihit, v_dhit,
                      v_eq, v_jr, v_addr, v_rv, v_rpc);
        if (cnt != 8) begin
          continue;
        end
        lines++;
        @(posedge clk);
        instr     <= v_instr;
        ihit      <= v_ihit;
        dhit      <= v_dhit;
        mm_equal  <= v_eq;
        jr_target <= v_jr;
        @(negedge clk);
        compare_word("imem_addr", v_addr, imem_addr);
        compare_bit("retire_valid", v_rv, retire_valid);
        if (v_ihit) begin
          fetched[v_addr] = v_instr;
        end
        // Retire PC only means something with the strobe.
        if (v_rv) begin
          compare_word("retire_pc", v_rpc, retire_pc);
          if (fetched.exists(v_rpc)) begin
            compare_op(expected_class(fetched[v_rpc]), retire_op);
          end else begin
            $display("Retire at %0t names PC %h, which was never fetched", $time, v_rpc);
            errors++;
          end
        end
      end
      $fclose(fd);
    end

    if (lines == 0) begin
      $display("No vectors were applied");
      errors++;
    end

    // Stop fetching and let the retire strobe fall.
    @(posedge clk);
    ihit <= 1'b0;
    instr <= '0;
    @(negedge clk);
    wait_cycles = 0;
    while (retire_valid === 1'b1 && wait_cycles < DRAIN_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (retire_valid === 1'b1) begin
      $display("Timed out waiting for the pipeline to drain");
      timed_out = 1'b1;
    end

    $display("Vectors: %0d, errors: %0d, timeout: %0d", lines, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/pipeline_vectors.txt
# instr ihit dhit mm_equal jr_target | exp_imem_addr exp_retire_valid exp_retire_pc
# One line per cycle, inputs driven at the rising edge, outputs checked at the falling edge.
20010001 1 1 0 00000000 00000000 0 00000000
20020002 1 1 0 00000000 00000004 0 00000000
8C230000 1 1 0 00000000 00000008 0 00000000
00622020 1 1 0 00000000 0000000C 0 00000000
14220000 1 1 0 00000000 00000010 0 00000000
14220000 1 1 0 00000000 00000010 1 00000000
10210003 1 1 0 00000000 00000014 1 00000004
20050005 1 1 0 00000000 00000018 1 00000008
20060006 1 1 1 00000000 0000001C 0 00000000
20070007 1 1 1 00000000 00000020 1 0000000C
0800000C 1 1 0 00000000 00000024 1 00000010
20080008 1 1 0 00000000 00000028 1 00000014
20090009 1 1 0 00000000 0000002C 0 00000000
03E00008 1 1 0 00000000 00000030 0 00000000
200A000A 1 1 0 00000000 00000034 0 00000000
200B000B 1 1 0 00000040 00000038 1 00000024
0C000014 1 1 0 00000000 00000040 0 00000000
200C000C 1 1 0 00000000 00000044 0 00000000
200D000D 1 1 0 00000000 00000048 1 00000030
AC410000 1 1 0 00000000 00000050 0 00000000
200E000E 0 1 0 00000000 00000054 0 00000000
200E000E 1 1 0 00000000 00000054 0 00000000
00000000 1 1 0 00000000 00000058 1 00000040
00000000 1 0 0 00000000 0000005C 0 00000000
00000000 1 0 0 00000000 0000005C 0 00000000
00000000 1 1 0 00000000 0000005C 0 00000000
00000000 1 1 0 00000000 00000060 0 00000000
00000000 1 1 0 00000000 00000064 1 00000050
00000000 1 1 0 00000000 00000068 1 00000054
00000000 1 1 0 00000000 0000006C 1 00000058

//--- sources.f
hw/pipeline_pkg.sv
hw/instr_decoder.sv
hw/hazard_control_unit.sv
hw/pc_unit.sv
hw/pipeline_tracker.sv
hw/pipeline_control_top.sv
testbench/tb_pipeline_control.sv

//--- Makefile
TOP = tb_pipeline_control

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
